// ==== design/perf_cnt_params.svh ====
`ifndef PERF_CNT_PARAMS_SVH
`define PERF_CNT_PARAMS_SVH

// Counter count and widths
`define PERF_NUM_CNT    4
`define PERF_HPM_WIDTH  40
`define PERF_ADDR_W     12

// Low-half counter CSR addresses
`define PERF_CSR_MCYCLE   12'hB00
`define PERF_CSR_MINSTRET 12'hB02
`define PERF_CSR_MHPM3    12'hB03
`define PERF_CSR_MHPM4    12'hB04

// High halves sit at a fixed offset from the low halves
`define PERF_CSR_HI_OFS   12'h080

// Counter inhibit register
`define PERF_CSR_INHIBIT  12'h320

`endif

// ==== design/perf_cnt_pkg.sv ====
`default_nettype none

`include "perf_cnt_params.svh"

package perf_cnt_pkg;

  // CSR bus words
  typedef logic [`PERF_ADDR_W-1:0] csr_addr_t;
  typedef logic [31:0]             csr_data_t;

  // Full 64-bit architectural view of any counter
  typedef logic [63:0] cnt_val_t;

  // One bit per counter, ordered as cnt_idx_e
  typedef logic [`PERF_NUM_CNT-1:0] cnt_mask_t;

  // Counter index
  typedef enum logic [1:0] {
    CNT_CYCLE   = 2'd0,
    CNT_INSTRET = 2'd1,
    CNT_HPM3    = 2'd2,
    CNT_HPM4    = 2'd3
  } cnt_idx_e;

endpackage

`default_nettype wire

// ==== design/perf_cnt_top.sv ====
`default_nettype none

`include "perf_cnt_params.svh"

module perf_cnt_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    csr_we_i,
  input  logic                    csr_re_i,
  input  perf_cnt_pkg::csr_addr_t csr_addr_i,
  input  perf_cnt_pkg::csr_data_t csr_wdata_i,
  input  logic                    instr_ret_i,
  input  logic [1:0]              hpm_event_i,

  output perf_cnt_pkg::csr_data_t csr_rdata_o,
  output logic                    csr_rvalid_o,
  output logic                    csr_err_o
);

  import perf_cnt_pkg::*;

  cnt_mask_t cnt_we;
  cnt_mask_t cnt_weh;
  cnt_mask_t cnt_inc;
  csr_data_t wr_val;
  logic      rd_en;
  cnt_idx_e  rd_idx;
  logic      rd_high;
  logic      rd_inhibit;
  cnt_mask_t inhibit;
  cnt_val_t  mcycle_val;
  cnt_val_t  minstret_val;
  cnt_val_t  mhpm3_val;
  cnt_val_t  mhpm4_val;

  perf_csr_decode u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_we_i     (csr_we_i),
    .csr_re_i     (csr_re_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .instr_ret_i  (instr_ret_i),
    .hpm_event_i  (hpm_event_i),
    .cnt_we_o     (cnt_we),
    .cnt_weh_o    (cnt_weh),
    .cnt_inc_o    (cnt_inc),
    .wr_val_o     (wr_val),
    .rd_en_o      (rd_en),
    .rd_idx_o     (rd_idx),
    .rd_high_o    (rd_high),
    .rd_inhibit_o (rd_inhibit),
    .inhibit_o    (inhibit),
    .csr_err_o    (csr_err_o)
  );

  perf_counter #(.CounterWidth(64)) u_mcycle (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .counter_inc_i (cnt_inc[CNT_CYCLE]),
    .counter_we_i  (cnt_we[CNT_CYCLE]),
    .counterh_we_i (cnt_weh[CNT_CYCLE]),
    .counter_val_i (wr_val),
    .counter_val_o (mcycle_val)
  );

  perf_counter #(.CounterWidth(64)) u_minstret (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .counter_inc_i (cnt_inc[CNT_INSTRET]),
    .counter_we_i  (cnt_we[CNT_INSTRET]),
    .counterh_we_i (cnt_weh[CNT_INSTRET]),
    .counter_val_i (wr_val),
    .counter_val_o (minstret_val)
  );

  // Event counters are narrower
  perf_counter #(.CounterWidth(`PERF_HPM_WIDTH)) u_mhpm3 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .counter_inc_i (cnt_inc[CNT_HPM3]),
    .counter_we_i  (cnt_we[CNT_HPM3]),
    .counterh_we_i (cnt_weh[CNT_HPM3]),
    .counter_val_i (wr_val),
    .counter_val_o (mhpm3_val)
  );

  perf_counter #(.CounterWidth(`PERF_HPM_WIDTH)) u_mhpm4 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .counter_inc_i (cnt_inc[CNT_HPM4]),
    .counter_we_i  (cnt_we[CNT_HPM4]),
    .counterh_we_i (cnt_weh[CNT_HPM4]),
    .counter_val_i (wr_val),
    .counter_val_o (mhpm4_val)
  );

  perf_csr_read u_read (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_en),
    .rd_idx_i     (rd_idx),
    .rd_high_i    (rd_high),
    .rd_inhibit_i (rd_inhibit),
    .inhibit_i    (inhibit),
    .cnt0_val_i   (mcycle_val),
    .cnt1_val_i   (minstret_val),
    .cnt2_val_i   (mhpm3_val),
    .cnt3_val_i   (mhpm4_val),
    .csr_rdata_o  (csr_rdata_o),
    .csr_rvalid_o (csr_rvalid_o)
  );

endmodule

`default_nettype wire

// ==== design/perf_counter.sv ====
`default_nettype none

module perf_counter #(
  parameter int CounterWidth = 64
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    counter_inc_i,
  input  logic                    counter_we_i,
  input  logic                    counterh_we_i,
  input  perf_cnt_pkg::csr_data_t counter_val_i,
  output perf_cnt_pkg::cnt_val_t  counter_val_o
);

  import perf_cnt_pkg::*;

  cnt_val_t                counter;
  cnt_val_t                counter_load;
  logic [CounterWidth-1:0] counter_q;
  logic [CounterWidth-1:0] counter_d;

  always_comb begin
    // Replace one half, keep the other
    if (counterh_we_i) begin
      counter_load = {counter_val_i, counter[31:0]};
    end else begin
      counter_load = {counter[63:32], counter_val_i};
    end

    // Writes win over the increment
    if (counter_we_i || counterh_we_i) begin
      counter_d = counter_load[CounterWidth-1:0];
    end else if (counter_inc_i) begin
      counter_d = counter_q + {{(CounterWidth-1){1'b0}}, 1'b1};
    end else begin
      counter_d = counter_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      counter_q <= '0;
    end else begin
      counter_q <= counter_d;
    end
  end

  // Upper bits of a narrow counter read as zero
  if (CounterWidth < 64) begin : g_narrow
    assign counter = {{(64-CounterWidth){1'b0}}, counter_q};
  end else begin : g_full
    assign counter = counter_q;
  end

  assign counter_val_o = counter;

  // Decode raises at most one half strobe per counter
  a_single_half: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(counter_we_i && counterh_we_i));

endmodule

`default_nettype wire

// ==== design/perf_csr_decode.sv ====
`default_nettype none

`include "perf_cnt_params.svh"

module perf_csr_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    csr_we_i,
  input  logic                    csr_re_i,
  input  perf_cnt_pkg::csr_addr_t csr_addr_i,
  input  perf_cnt_pkg::csr_data_t csr_wdata_i,
  input  logic                    instr_ret_i,
  input  logic [1:0]              hpm_event_i,

  output perf_cnt_pkg::cnt_mask_t cnt_we_o,
  output perf_cnt_pkg::cnt_mask_t cnt_weh_o,
  output perf_cnt_pkg::cnt_mask_t cnt_inc_o,
  output perf_cnt_pkg::csr_data_t wr_val_o,

  output logic                    rd_en_o,
  output perf_cnt_pkg::cnt_idx_e  rd_idx_o,
  output logic                    rd_high_o,
  output logic                    rd_inhibit_o,

  output perf_cnt_pkg::cnt_mask_t inhibit_o,
  output logic                    csr_err_o
);

  import perf_cnt_pkg::*;

  cnt_mask_t lo_hit;
  cnt_mask_t hi_hit;
  logic      inh_hit;
  logic      addr_ok;
  cnt_idx_e  hit_idx;
  cnt_mask_t inhibit_q;
  cnt_mask_t events;
  logic      err_q;

  // Address match
  always_comb begin
    lo_hit  = '0;
    hi_hit  = '0;
    inh_hit = 1'b0;
    hit_idx = CNT_CYCLE;
    case (csr_addr_i)
      `PERF_CSR_MCYCLE: begin
        lo_hit[CNT_CYCLE] = 1'b1;
      end
      `PERF_CSR_MINSTRET: begin
        lo_hit[CNT_INSTRET] = 1'b1;
        hit_idx             = CNT_INSTRET;
      end
      `PERF_CSR_MHPM3: begin
        lo_hit[CNT_HPM3] = 1'b1;
        hit_idx          = CNT_HPM3;
      end
      `PERF_CSR_MHPM4: begin
        lo_hit[CNT_HPM4] = 1'b1;
        hit_idx          = CNT_HPM4;
      end
      `PERF_CSR_MCYCLE + `PERF_CSR_HI_OFS: begin
        hi_hit[CNT_CYCLE] = 1'b1;
      end
      `PERF_CSR_MINSTRET + `PERF_CSR_HI_OFS: begin
        hi_hit[CNT_INSTRET] = 1'b1;
        hit_idx             = CNT_INSTRET;
      end
      `PERF_CSR_MHPM3 + `PERF_CSR_HI_OFS: begin
        hi_hit[CNT_HPM3] = 1'b1;
        hit_idx          = CNT_HPM3;
      end
      `PERF_CSR_MHPM4 + `PERF_CSR_HI_OFS: begin
        hi_hit[CNT_HPM4] = 1'b1;
        hit_idx          = CNT_HPM4;
      end
      `PERF_CSR_INHIBIT: begin
        inh_hit = 1'b1;
      end
      default: begin
        inh_hit = 1'b0;
      end
    endcase
  end

  assign addr_ok = (|lo_hit) | (|hi_hit) | inh_hit;

  // Counter writes land on the same edge as the strobe
  assign cnt_we_o  = csr_we_i ? lo_hit : '0;
  assign cnt_weh_o = csr_we_i ? hi_hit : '0;
  assign wr_val_o  = csr_wdata_i;

  // Architectural inhibit bits 0, 2, 3, 4 packed into four bits
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (csr_we_i && inh_hit) begin
      inhibit_q <= {csr_wdata_i[4], csr_wdata_i[3], csr_wdata_i[2], csr_wdata_i[0]};
    end
  end

  assign inhibit_o = inhibit_q;

  // Cycle counter counts every cycle
  assign events    = {hpm_event_i[1], hpm_event_i[0], instr_ret_i, 1'b1};
  assign cnt_inc_o = events & ~inhibit_q;

  // Read selection goes straight to the read side, which holds the register stage
  assign rd_en_o      = csr_re_i & addr_ok;
  assign rd_idx_o     = hit_idx;
  assign rd_high_o    = |hi_hit;
  assign rd_inhibit_o = inh_hit;

  // One-cycle error pulse for any undecoded access
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= (csr_we_i | csr_re_i) & ~addr_ok;
    end
  end

  assign csr_err_o = err_q;

  a_one_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({cnt_weh_o, cnt_we_o}));

  // The core never issues a read and a write in the same cycle
  a_no_rd_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(csr_we_i && csr_re_i));

endmodule

`default_nettype wire

// ==== design/perf_csr_read.sv ====
`default_nettype none

module perf_csr_read (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    rd_en_i,
  input  perf_cnt_pkg::cnt_idx_e  rd_idx_i,
  input  logic                    rd_high_i,
  input  logic                    rd_inhibit_i,
  input  perf_cnt_pkg::cnt_mask_t inhibit_i,

  input  perf_cnt_pkg::cnt_val_t  cnt0_val_i,
  input  perf_cnt_pkg::cnt_val_t  cnt1_val_i,
  input  perf_cnt_pkg::cnt_val_t  cnt2_val_i,
  input  perf_cnt_pkg::cnt_val_t  cnt3_val_i,

  output perf_cnt_pkg::csr_data_t csr_rdata_o,
  output logic                    csr_rvalid_o
);

  import perf_cnt_pkg::*;

  cnt_val_t  cnt_sel;
  csr_data_t inhibit_word;
  csr_data_t rdata_d;
  csr_data_t rdata_q;
  logic      rvalid_q;

  always_comb begin
    case (rd_idx_i)
      CNT_CYCLE:   cnt_sel = cnt0_val_i;
      CNT_INSTRET: cnt_sel = cnt1_val_i;
      CNT_HPM3:    cnt_sel = cnt2_val_i;
      default:     cnt_sel = cnt3_val_i;
    endcase

    // Back to architectural positions, bit 1 stays zero
    inhibit_word    = '0;
    inhibit_word[0] = inhibit_i[CNT_CYCLE];
    inhibit_word[2] = inhibit_i[CNT_INSTRET];
    inhibit_word[3] = inhibit_i[CNT_HPM3];
    inhibit_word[4] = inhibit_i[CNT_HPM4];

    if (rd_inhibit_i) begin
      rdata_d = inhibit_word;
    end else if (rd_high_i) begin
      rdata_d = cnt_sel[63:32];
    end else begin
      rdata_d = cnt_sel[31:0];
    end
  end

  // Data holds until the next read
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rdata_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en_i;
      if (rd_en_i) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign csr_rdata_o  = rdata_q;
  assign csr_rvalid_o = rvalid_q;

  a_rd_en_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(rd_en_i));

endmodule

`default_nettype wire

// ==== dv/perf_cnt_input.txt ====
# op addr wdata instret event expected err, all hex; '-' in instret or event draws random bits
# '-' in expected takes the running count kept by the testbench
R B00 00000000 0 0 - 0
R B80 00000000 0 0 00000000 0
R B02 00000000 0 0 00000000 0
R B82 00000000 0 0 00000000 0
R B03 00000000 0 0 00000000 0
R B83 00000000 0 0 00000000 0
R B04 00000000 0 0 00000000 0
R B84 00000000 0 0 00000000 0
R 320 00000000 0 0 00000000 0
W B02 12345678 0 0 - 0
W B82 AABBCCDD 0 0 - 0
W B02 00000001 0 0 - 0
R B82 00000000 0 0 AABBCCDD 0
R B02 00000000 0 0 00000001 0
W B00 FFFFFFFF 0 0 - 0
R B00 00000000 0 0 FFFFFFFF 0
R B80 00000000 0 0 00000001 0
I 000 00000000 - - - 0
I 000 00000000 - - - 0
I 000 00000000 - - - 0
I 000 00000000 - - - 0
I 000 00000000 - - - 0
R B02 00000000 0 0 - 0
R B03 00000000 0 0 - 0
R B04 00000000 0 0 - 0
W B83 FFFFFFFF 0 0 - 0
R B83 00000000 0 0 000000FF 0
W B03 FFFFFFFE 0 0 - 0
I 000 00000000 0 1 - 0
I 000 00000000 0 1 - 0
R B03 00000000 0 0 00000000 0
R B83 00000000 0 0 00000000 0
W 320 0000001F 0 0 - 0
R 320 00000000 0 0 0000001D 0
W B02 00000010 0 0 - 0
I 000 00000000 1 3 - 0
R B00 00000000 1 3 - 0
R B00 00000000 1 3 - 0
R B02 00000000 0 0 00000010 0
W 320 00000010 0 0 - 0
I 000 00000000 0 3 - 0
I 000 00000000 0 3 - 0
R B03 00000000 0 0 00000002 0
R B04 00000000 0 0 - 0
W B01 12345678 0 0 - 1
R C00 00000000 0 0 - 1
W 321 0000FFFF 0 0 - 1
R B02 00000000 0 0 00000010 0

// ==== dv/perf_cnt_tb.sv ====
`default_nettype none

`include "perf_cnt_params.svh"

module perf_cnt_tb;

  import perf_cnt_pkg::*;

  localparam int HpmWidth = `PERF_HPM_WIDTH;

  logic       clk;
  logic       rst_n;
  logic       csr_we;
  logic       csr_re;
  csr_addr_t  csr_addr;
  csr_data_t  csr_wdata;
  logic       instr_ret;
  logic [1:0] hpm_event;
  csr_data_t  csr_rdata;
  logic       csr_rvalid;
  logic       csr_err;

  // One entry per stimulus line
  byte        op_q[$];
  csr_addr_t  addr_q[$];
  csr_data_t  wdata_q[$];
  logic       ret_q[$];
  logic [1:0] evt_q[$];
  bit         rand_q[$];
  csr_data_t  exp_q[$];
  bit         use_ref_q[$];
  bit         err_q[$];

  // Running counts and the architectural inhibit word
  cnt_val_t   ref_cnt [4];
  csr_data_t  ref_inh_word;
  csr_data_t  last_rdata;

  int seed;
  int errors;
  int cycles = 0;
  int limit;

  perf_cnt_top UUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .csr_we_i     (csr_we),
    .csr_re_i     (csr_re),
    .csr_addr_i   (csr_addr),
    .csr_wdata_i  (csr_wdata),
    .instr_ret_i  (instr_ret),
    .hpm_event_i  (hpm_event),
    .csr_rdata_o  (csr_rdata),
    .csr_rvalid_o (csr_rvalid),
    .csr_err_o    (csr_err)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, %0d errors so far", cycles, errors);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic csr_data_t hex_field(input string s);
    csr_data_t word;
    word = '0;
    if (s != "-") begin
      void'($sscanf(s, "%h", word));
    end
    return word;
  endfunction

  task automatic load_steps();
    int        fd;
    int        n;
    string     line;
    string     op_s, addr_s, data_s, ret_s, evt_s, exp_s, err_s;
    csr_data_t word;
    fd = $fopen("dv/perf_cnt_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file dv/perf_cnt_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip comment and blank lines
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %s %s %s %s %s",
                    op_s, addr_s, data_s, ret_s, evt_s, exp_s, err_s);
        if (n == 7) begin
          op_q.push_back(op_s.getc(0));
          word = hex_field(addr_s);
          addr_q.push_back(word[`PERF_ADDR_W-1:0]);
          wdata_q.push_back(hex_field(data_s));
          word = hex_field(ret_s);
          ret_q.push_back(word[0]);
          word = hex_field(evt_s);
          evt_q.push_back(word[1:0]);
          rand_q.push_back(ret_s == "-" || evt_s == "-");
          exp_q.push_back(hex_field(exp_s));
          use_ref_q.push_back(exp_s == "-");
          word = hex_field(err_s);
          err_q.push_back(word[0]);
        end
      end
    end
    $fclose(fd);
  endtask

  // Counter index and half, -1 for the inhibit register, -2 if undecoded
  function automatic int ref_target(input csr_addr_t addr, output bit high);
    csr_addr_t base [4];
    int        i;
    base[0] = `PERF_CSR_MCYCLE;
    base[1] = `PERF_CSR_MINSTRET;
    base[2] = `PERF_CSR_MHPM3;
    base[3] = `PERF_CSR_MHPM4;
    high = 1'b0;
    if (addr == `PERF_CSR_INHIBIT) begin
      return -1;
    end
    for (i = 0; i < 4; i++) begin
      if (addr == base[i]) begin
        return i;
      end
      if (addr == base[i] + `PERF_CSR_HI_OFS) begin
        high = 1'b1;
        return i;
      end
    end
    return -2;
  endfunction

  function automatic cnt_val_t width_mask(input int idx);
    if (idx < 2) begin
      return '1;
    end
    return (64'd1 << HpmWidth) - 64'd1;
  endfunction

  // Architectural inhibit position of a counter, bit 1 is unused
  function automatic int inhibit_bit(input int idx);
    if (idx == 0) begin
      return 0;
    end
    return idx + 1;
  endfunction

  // Event level that a counter sees in the current cycle
  function automatic bit event_active(input int idx);
    case (idx)
      0:       return 1'b1;
      1:       return instr_ret;
      2:       return hpm_event[0];
      default: return hpm_event[1];
    endcase
  endfunction

  function automatic csr_data_t ref_read(input csr_addr_t addr);
    int        tgt;
    bit        high;
    csr_data_t word;
    tgt  = ref_target(addr, high);
    word = '0;
    if (tgt == -1) begin
      word = ref_inh_word;
    end else if (tgt >= 0) begin
      word = high ? ref_cnt[tgt][63:32] : ref_cnt[tgt][31:0];
    end
    return word;
  endfunction

  // Apply one clock edge to the running counts
  task automatic update_ref();
    int        tgt;
    int        i;
    bit        high;
    bit        wr;
    tgt = ref_target(csr_addr, high);
    wr  = csr_we && (tgt != -2);
    for (i = 0; i < 4; i++) begin
      if (wr && tgt == i) begin
        if (high) begin
          ref_cnt[i] = {csr_wdata, ref_cnt[i][31:0]} & width_mask(i);
        end else begin
          ref_cnt[i] = {ref_cnt[i][63:32], csr_wdata} & width_mask(i);
        end
      end else if (event_active(i) && !ref_inh_word[inhibit_bit(i)]) begin
        ref_cnt[i] = (ref_cnt[i] + 64'd1) & width_mask(i);
      end
    end
    if (wr && tgt == -1) begin
      // Only positions 0, 2, 3 and 4 are implemented
      ref_inh_word = csr_wdata & 32'h0000001D;
    end
  endtask

  task automatic drive_step(input int idx);
    logic [31:0] rnd;
    csr_we    = (op_q[idx] == "W");
    csr_re    = (op_q[idx] == "R");
    csr_addr  = addr_q[idx];
    csr_wdata = wdata_q[idx];
    if (rand_q[idx]) begin
      rnd       = $random(seed);
      instr_ret = rnd[0];
      hpm_event = rnd[2:1];
    end else begin
      instr_ret = ret_q[idx];
      hpm_event = evt_q[idx];
    end
  endtask

  task automatic check_outputs(input int step, input logic exp_valid, input logic exp_err,
                               input csr_data_t exp_data);
    if (csr_rvalid !== exp_valid) begin
      $display("ERROR: step %0d csr_rvalid_o expected %h got %h", step, exp_valid, csr_rvalid);
      errors++;
    end
    if (csr_err !== exp_err) begin
      $display("ERROR: step %0d csr_err_o expected %h got %h", step, exp_err, csr_err);
      errors++;
    end
    if (csr_rdata !== exp_data) begin
      $display("ERROR: step %0d csr_rdata_o expected %h got %h", step, exp_data, csr_rdata);
      errors++;
    end
  endtask

  initial begin
    bit exp_valid;
    int i;
    clk          = 1'b0;
    rst_n        = 1'b0;
    csr_we       = 1'b0;
    csr_re       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    instr_ret    = 1'b0;
    hpm_event    = '0;
    seed         = 32'h3ba0;
    errors       = 0;
    limit        = 0;
    last_rdata   = '0;
    ref_inh_word = '0;
    for (i = 0; i < 4; i++) begin
      ref_cnt[i] = '0;
    end
    load_steps();
    limit = op_q.size() + 50;

    repeat (5) @(posedge clk);
    #1;
    // Outputs right after reset, reported as step -1
    check_outputs(-1, 1'b0, 1'b0, '0);
    #1;
    rst_n = 1'b1;

    for (i = 0; i < op_q.size(); i++) begin
      drive_step(i);
      exp_valid = (op_q[i] == "R") && !err_q[i];
      // Read data is the value held during the strobe cycle
      if (exp_valid) begin
        last_rdata = use_ref_q[i] ? ref_read(csr_addr) : exp_q[i];
      end
      @(posedge clk);
      update_ref();
      #1;
      check_outputs(i, exp_valid, err_q[i], last_rdata);
      #1;
    end

    csr_we = 1'b0;
    csr_re = 1'b0;
    $display("Run finished: %0d errors over %0d steps", errors, op_q.size());
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the performance counter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module perf_cnt_tb \
  -f sim.f \
  -o perf_cnt_sim

./obj_dir/perf_cnt_sim | tee "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"

// ==== sim.f ====
+incdir+design
design/perf_cnt_pkg.sv
design/perf_csr_decode.sv
design/perf_counter.sv
design/perf_csr_read.sv
design/perf_cnt_top.sv
dv/perf_cnt_tb.sv
